// File: src/cnn_pkg.sv
package cnn_pkg;

	// data and lane geometry
	localparam int DATA_WIDTH = 16; // float16
	localparam int PARA_Y = 3; // slices per ram word

	// feature map ram, two halves for ping-pong
	localparam int FM_RAM_DEPTH = 256;
	localparam int FM_RAM_HALF = 128; // base of the upper half
	localparam int FM_ADDR_WIDTH = 8;

	// layer configuration field widths
	localparam int FM_SIZE_WIDTH = 5; // fm_size up to 8
	localparam int POOL_WIN_WIDTH = 2; // window 1 to 3
	localparam int GROUP_WIDTH = 2; // slice groups of PARA_Y
	localparam int LAYER_NUM_WIDTH = 4;

	typedef logic [DATA_WIDTH-1:0] fp16_t;

	// lane k holds slice k of the group
	typedef fp16_t [PARA_Y-1:0] fm_word_t;

	typedef logic [FM_ADDR_WIDTH-1:0] fm_addr_t;

	typedef struct packed {
		logic en;
		logic we; // 1 write, 0 read
		fm_addr_t addr;
		fm_word_t wdata;
	} ram_req_t;

	typedef enum logic {
		LAYER_LOAD = 1'b0,
		LAYER_POOL = 1'b1
	} layer_type_t;

	typedef struct packed {
		logic [FM_SIZE_WIDTH-1:0] fm_size;
		logic [GROUP_WIDTH-1:0] fm_groups; // number of groups in use
		logic [POOL_WIN_WIDTH-1:0] pool_win;
	} layer_cfg_t;

	// true when a > b, +0 ranks above -0, no NaN handling
	function automatic logic fp16_greater(input fp16_t a, input fp16_t b);
		logic gt;
		if (a[DATA_WIDTH-1] != b[DATA_WIDTH-1]) begin
			gt = b[DATA_WIDTH-1]; // only a positive a wins
		end else if (!a[DATA_WIDTH-1]) begin
			gt = a[DATA_WIDTH-2:0] > b[DATA_WIDTH-2:0];
		end else begin
			// both negative, smaller magnitude is larger
			gt = a[DATA_WIDTH-2:0] < b[DATA_WIDTH-2:0];
		end
		return gt;
	endfunction

endpackage

// File: src/fm_ram.sv
`timescale 1ns/100ps

module fm_ram (
	input  logic              clk,
	input  cnn_pkg::ram_req_t req_i,
	output cnn_pkg::fm_word_t rdata_o
);

	cnn_pkg::fm_word_t mem [cnn_pkg::FM_RAM_DEPTH];

	// single port, write or read per cycle
	always_ff @(posedge clk) begin
		if (req_i.en) begin
			if (req_i.we) begin
				mem[req_i.addr] <= req_i.wdata;
			end else begin
				rdata_o <= mem[req_i.addr]; // data one cycle later
			end
		end
	end

endmodule

// File: src/fm_ram_arbiter.sv
`timescale 1ns/100ps

module fm_ram_arbiter (
	input  logic              clk,
	input  logic              rst,
	input  cnn_pkg::ram_req_t host_req_i,
	input  cnn_pkg::ram_req_t engine_req_i,
	output cnn_pkg::ram_req_t ram_req_o,
	input  cnn_pkg::fm_word_t ram_rdata_i,
	output logic              engine_gnt_o,
	output logic              engine_rvalid_o,
	output logic              host_rvalid_o,
	output cnn_pkg::fm_word_t rdata_o
);

	logic rd_valid_q; // a read was issued last cycle
	logic rd_owner_q; // 1 engine, 0 host

	// host always wins, engine holds its request until granted
	assign engine_gnt_o = engine_req_i.en & ~host_req_i.en;

	assign ram_req_o = host_req_i.en ? host_req_i : engine_req_i;

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			rd_valid_q <= 1'b0;
			rd_owner_q <= 1'b0;
		end else begin
			rd_valid_q <= ram_req_o.en & ~ram_req_o.we;
			rd_owner_q <= ~host_req_i.en;
		end
	end

	// returned word goes to whoever owned the read
	assign host_rvalid_o = rd_valid_q & ~rd_owner_q;
	assign engine_rvalid_o = rd_valid_q & rd_owner_q;
	assign rdata_o = ram_rdata_i;

endmodule

// File: src/max_pool_unit.sv
`timescale 1ns/100ps

module max_pool_unit (
	input  logic              clk,
	input  logic              rst,
	input  logic              clear_i,
	input  logic              sample_valid_i,
	input  cnn_pkg::fm_word_t sample_i,
	output cnn_pkg::fm_word_t result_o
);

	cnn_pkg::fm_word_t acc_q;
	logic first_q; // next sample opens a new window
	logic load_first;

	// first sample of a window loads the lanes directly
	assign load_first = clear_i | first_q;

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			first_q <= 1'b0;
		end else if (sample_valid_i) begin
			first_q <= 1'b0;
		end else if (clear_i) begin
			first_q <= 1'b1;
		end
	end

	// one running maximum per slice lane
	always_ff @(posedge clk) begin
		if (sample_valid_i) begin
			for (int k = 0; k < cnn_pkg::PARA_Y; k++) begin
				if (load_first || cnn_pkg::fp16_greater(sample_i[k], acc_q[k])) begin
					acc_q[k] <= sample_i[k];
				end
			end
		end
	end

	assign result_o = acc_q; // valid the cycle after the last sample

endmodule

// File: src/pool_engine.sv
`timescale 1ns/100ps

module pool_engine (
	input  logic                clk,
	input  logic                rst,
	input  logic                start_i,
	input  logic                src_half_i,
	input  cnn_pkg::layer_cfg_t cfg_i,
	output cnn_pkg::ram_req_t   req_o,
	input  logic                gnt_i,
	input  logic                rvalid_i,
	input  cnn_pkg::fm_word_t   rdata_i,
	output logic                done_o
);

	typedef enum logic [1:0] {
		S_IDLE,
		S_READ,
		S_WAIT,
		S_WRITE
	} state_t;

	state_t state_q;
	logic src_half_q;
	logic [cnn_pkg::GROUP_WIDTH-1:0] grp_q;
	logic [cnn_pkg::FM_SIZE_WIDTH-1:0] row_q; // window top row
	logic [cnn_pkg::FM_SIZE_WIDTH-1:0] col_q; // window left column
	logic [cnn_pkg::POOL_WIN_WIDTH-1:0] wy_q;
	logic [cnn_pkg::POOL_WIN_WIDTH-1:0] wx_q;
	logic [3:0] rcnt_q; // samples returned in this window
	cnn_pkg::fm_addr_t out_addr_q;
	logic clear_q;

	cnn_pkg::fm_word_t pool_result;
	logic [3:0] nsamp;
	logic [cnn_pkg::FM_SIZE_WIDTH:0] win_x2;
	logic [cnn_pkg::FM_SIZE_WIDTH:0] col_end;
	logic [cnn_pkg::FM_SIZE_WIDTH:0] row_end;
	logic win_last;
	logic col_last;
	logic row_last;
	logic grp_last;
	cnn_pkg::fm_addr_t src_base;
	cnn_pkg::fm_addr_t row_idx;
	cnn_pkg::fm_addr_t in_addr;

	assign nsamp = {2'b00, cfg_i.pool_win} * {2'b00, cfg_i.pool_win};
	assign win_last = (wy_q == cfg_i.pool_win - 1'b1) && (wx_q == cfg_i.pool_win - 1'b1);

	// a following window must fit inside the map, leftovers are skipped
	assign win_x2 = {{(cnn_pkg::FM_SIZE_WIDTH - cnn_pkg::POOL_WIN_WIDTH){1'b0}},
		cfg_i.pool_win, 1'b0};
	assign col_end = {1'b0, col_q} + win_x2;
	assign row_end = {1'b0, row_q} + win_x2;
	assign col_last = col_end > {1'b0, cfg_i.fm_size};
	assign row_last = row_end > {1'b0, cfg_i.fm_size};
	assign grp_last = grp_q == cfg_i.fm_groups - 1'b1;

	// src base + (group * fm_size + row) * fm_size + col
	assign src_base = src_half_q ? cnn_pkg::fm_addr_t'(cnn_pkg::FM_RAM_HALF) : '0;
	assign row_idx = cnn_pkg::fm_addr_t'(grp_q) * cnn_pkg::fm_addr_t'(cfg_i.fm_size)
		+ cnn_pkg::fm_addr_t'(row_q) + cnn_pkg::fm_addr_t'(wy_q);
	assign in_addr = src_base + row_idx * cnn_pkg::fm_addr_t'(cfg_i.fm_size)
		+ cnn_pkg::fm_addr_t'(col_q) + cnn_pkg::fm_addr_t'(wx_q);

	always_comb begin
		req_o = '0;
		case (state_q)
			S_READ: begin
				req_o.en = 1'b1;
				req_o.addr = in_addr;
			end
			S_WRITE: begin
				req_o.en = 1'b1;
				req_o.we = 1'b1;
				req_o.addr = out_addr_q;
				req_o.wdata = pool_result;
			end
			default: ;
		endcase
	end

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			state_q <= S_IDLE;
			src_half_q <= 1'b0;
			grp_q <= '0;
			row_q <= '0;
			col_q <= '0;
			wy_q <= '0;
			wx_q <= '0;
			rcnt_q <= '0;
			out_addr_q <= '0;
			clear_q <= 1'b0;
			done_o <= 1'b0;
		end else begin
			clear_q <= 1'b0;
			done_o <= 1'b0;
			if (rvalid_i) begin
				rcnt_q <= rcnt_q + 1'b1;
			end
			case (state_q)
				S_IDLE: begin
					if (start_i) begin
						src_half_q <= src_half_i;
						// outputs are dense, written in order from the other base
						out_addr_q <= src_half_i ? '0 : cnn_pkg::fm_addr_t'(cnn_pkg::FM_RAM_HALF);
						grp_q <= '0;
						row_q <= '0;
						col_q <= '0;
						wy_q <= '0;
						wx_q <= '0;
						rcnt_q <= '0;
						clear_q <= 1'b1;
						state_q <= S_READ;
					end
				end
				S_READ: begin
					if (gnt_i) begin
						if (wx_q == cfg_i.pool_win - 1'b1) begin
							wx_q <= '0;
							if (win_last) begin
								wy_q <= '0;
								state_q <= S_WAIT; // last read of the window issued
							end else begin
								wy_q <= wy_q + 1'b1;
							end
						end else begin
							wx_q <= wx_q + 1'b1;
						end
					end
				end
				S_WAIT: begin
					if (rvalid_i && rcnt_q == nsamp - 1'b1) begin
						rcnt_q <= '0;
						state_q <= S_WRITE;
					end
				end
				S_WRITE: begin
					if (gnt_i) begin
						out_addr_q <= out_addr_q + 1'b1;
						if (!col_last) begin
							col_q <= col_q + cfg_i.pool_win;
						end else begin
							col_q <= '0;
							if (!row_last) begin
								row_q <= row_q + cfg_i.pool_win;
							end else begin
								row_q <= '0;
								if (!grp_last) begin
									grp_q <= grp_q + 1'b1;
								end
							end
						end
						if (col_last && row_last && grp_last) begin
							done_o <= 1'b1;
							state_q <= S_IDLE;
						end else begin
							clear_q <= 1'b1;
							state_q <= S_READ;
						end
					end
				end
				default: state_q <= S_IDLE;
			endcase
		end
	end

	max_pool_unit u_max_pool_unit (
		.clk            (clk),
		.rst            (rst),
		.clear_i        (clear_q),
		.sample_valid_i (rvalid_i),
		.sample_i       (rdata_i),
		.result_o       (pool_result)
	);

endmodule

// File: src/layer_sequencer.sv
`timescale 1ns/100ps

module layer_sequencer (
	input  logic                                 clk,
	input  logic                                 rst,
	input  logic [cnn_pkg::LAYER_NUM_WIDTH-1:0] layer_num_i,
	input  cnn_pkg::layer_type_t                 layer_type_i,
	input  logic                                 init_done_i,
	input  logic                                 engine_done_i,
	output logic                                 start_o,
	output logic                                 src_half_o,
	output logic                                 layer_ready_o
);

	logic [cnn_pkg::LAYER_NUM_WIDTH-1:0] cur_layer_q;
	logic started_q; // engine already kicked for this layer

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			cur_layer_q <= '0;
			started_q <= 1'b0;
			start_o <= 1'b0;
			src_half_o <= 1'b0;
			layer_ready_o <= 1'b0;
		end else begin
			start_o <= 1'b0;
			if (layer_num_i != cur_layer_q) begin
				// new layer is coming
				cur_layer_q <= layer_num_i;
				started_q <= 1'b0;
				layer_ready_o <= 1'b0;
			end else if (layer_type_i == cnn_pkg::LAYER_LOAD) begin
				layer_ready_o <= init_done_i; // host finished loading
			end else begin
				if (!started_q) begin
					start_o <= 1'b1;
					started_q <= 1'b1;
				end
				if (engine_done_i) begin
					src_half_o <= ~src_half_o; // results become next source
					layer_ready_o <= 1'b1;
				end
			end
		end
	end

endmodule

// File: src/cnn_pool_top.sv
`timescale 1ns/100ps

module cnn_pool_top (
	input  logic                                 clk,
	input  logic                                 rst,
	input  cnn_pkg::ram_req_t                    host_req_i,
	output cnn_pkg::fm_word_t                    host_rdata_o,
	output logic                                 host_rvalid_o,
	input  logic [cnn_pkg::LAYER_NUM_WIDTH-1:0] layer_num_i,
	input  cnn_pkg::layer_type_t                 layer_type_i,
	input  cnn_pkg::layer_cfg_t                  layer_cfg_i,
	input  logic                                 init_done_i,
	output logic                                 layer_ready_o
);

	cnn_pkg::ram_req_t engine_req;
	cnn_pkg::ram_req_t ram_req;
	cnn_pkg::fm_word_t ram_rdata;
	logic engine_gnt;
	logic engine_rvalid;
	logic engine_start;
	logic engine_done;
	logic src_half;

	fm_ram u_fm_ram (
		.clk     (clk),
		.req_i   (ram_req),
		.rdata_o (ram_rdata)
	);

	// returned word is shared, each side qualifies it with its own valid
	fm_ram_arbiter u_fm_ram_arbiter (
		.clk             (clk),
		.rst             (rst),
		.host_req_i      (host_req_i),
		.engine_req_i    (engine_req),
		.ram_req_o       (ram_req),
		.ram_rdata_i     (ram_rdata),
		.engine_gnt_o    (engine_gnt),
		.engine_rvalid_o (engine_rvalid),
		.host_rvalid_o   (host_rvalid_o),
		.rdata_o         (host_rdata_o)
	);

	pool_engine u_pool_engine (
		.clk        (clk),
		.rst        (rst),
		.start_i    (engine_start),
		.src_half_i (src_half),
		.cfg_i      (layer_cfg_i),
		.req_o      (engine_req),
		.gnt_i      (engine_gnt),
		.rvalid_i   (engine_rvalid),
		.rdata_i    (host_rdata_o),
		.done_o     (engine_done)
	);

	layer_sequencer u_layer_sequencer (
		.clk           (clk),
		.rst           (rst),
		.layer_num_i   (layer_num_i),
		.layer_type_i  (layer_type_i),
		.init_done_i   (init_done_i),
		.engine_done_i (engine_done),
		.start_o       (engine_start),
		.src_half_o    (src_half),
		.layer_ready_o (layer_ready_o)
	);

endmodule

// File: tb/tb_cnn_pool_top.sv
`timescale 1ns/100ps

module tb_cnn_pool_top;

	localparam int CLK_PERIOD = 4;
	localparam int N_LOAD = 104; // 72 words in half 0, 32 in half 1
	localparam int N_READS = 165; // readback, busy reads and results
	localparam int LAYER_CYCLES = 3 * (2 * 6 * 6 * 2 + 2 * 3 * 3 * 2);
	localparam int WATCHDOG_CYCLES = 2 * (N_LOAD + N_READS + LAYER_CYCLES) + 100;

	logic clk;
	logic rst;
	cnn_pkg::ram_req_t host_req;
	cnn_pkg::fm_word_t host_rdata;
	logic host_rvalid;
	logic [cnn_pkg::LAYER_NUM_WIDTH-1:0] layer_num;
	cnn_pkg::layer_type_t layer_type;
	cnn_pkg::layer_cfg_t layer_cfg;
	logic init_done;
	logic layer_ready;

	cnn_pkg::fm_word_t model_mem [cnn_pkg::FM_RAM_DEPTH]; // mirror of the ram
	cnn_pkg::fm_word_t w;
	int errors;
	int seed;

	// expectations registered at the edge that takes the request
	logic pend_rd;
	cnn_pkg::fm_word_t pend_word;
	logic [cnn_pkg::LAYER_NUM_WIDTH-1:0] num_prev;
	logic num_chg_q;
	logic load_q;
	logic init_q;

	cnn_pool_top dut (
		.clk           (clk),
		.rst           (rst),
		.host_req_i    (host_req),
		.host_rdata_o  (host_rdata),
		.host_rvalid_o (host_rvalid),
		.layer_num_i   (layer_num),
		.layer_type_i  (layer_type),
		.layer_cfg_i   (layer_cfg),
		.init_done_i   (init_done),
		.layer_ready_o (layer_ready)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	initial begin
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		$display("Timeout: the run did not finish, layer_ready_o probably never rose");
		$display("Errors: %0d", errors);
		$display("Verification failed");
		$finish;
	end

	always @(posedge clk or negedge rst) begin
		if (!rst) begin
			pend_rd <= 1'b0;
			pend_word <= '0;
			num_prev <= '0;
			num_chg_q <= 1'b0;
			load_q <= 1'b0;
			init_q <= 1'b0;
		end else begin
			pend_rd <= host_req.en && !host_req.we;
			pend_word <= model_mem[host_req.addr];
			num_prev <= layer_num;
			num_chg_q <= layer_num != num_prev;
			load_q <= layer_type == cnn_pkg::LAYER_LOAD;
			init_q <= init_done;
		end
	end

	rvalid_check: assert property (@(posedge clk) disable iff (!rst) host_rvalid == pend_rd)
		else begin
			errors++;
			$display("Fail %0t host_rvalid_o expected %b got %b", $time,
				$sampled(pend_rd), $sampled(host_rvalid));
		end

	rdata_check: assert property (@(posedge clk) disable iff (!rst)
		pend_rd |-> host_rdata == pend_word)
		else begin
			errors++;
			$display("Fail %0t host_rdata_o expected %h got %h", $time,
				$sampled(pend_word), $sampled(host_rdata));
		end

	ready_drop_check: assert property (@(posedge clk) disable iff (!rst)
		num_chg_q |-> !layer_ready)
		else begin
			errors++;
			$display("Fail %0t layer_ready_o expected 0 got 1", $time);
		end

	// in load mode ready follows init_done one cycle later
	ready_load_check: assert property (@(posedge clk) disable iff (!rst)
		(load_q && !num_chg_q) |-> layer_ready == init_q)
		else begin
			errors++;
			$display("Fail %0t layer_ready_o expected %b got %b", $time,
				$sampled(init_q), $sampled(layer_ready));
		end

	// ordering key with negatives reversed so -0 lands just below +0
	function automatic logic [15:0] order_key(input cnn_pkg::fp16_t v);
		return v[15] ? {1'b0, ~v[14:0]} : {1'b1, v[14:0]};
	endfunction

	function automatic cnn_pkg::fp16_t larger_fp16(input cnn_pkg::fp16_t a,
		input cnn_pkg::fp16_t b);
		return (order_key(a) >= order_key(b)) ? a : b;
	endfunction

	function automatic cnn_pkg::fm_word_t rand_word();
		cnn_pkg::fm_word_t r;
		for (int k = 0; k < cnn_pkg::PARA_Y; k++) begin
			r[k] = cnn_pkg::fp16_t'($random(seed));
			r[k][14] = 1'b0; // exponent msb cleared so no inf or NaN
		end
		return r;
	endfunction

	task automatic host_write(input int a, input cnn_pkg::fm_word_t d);
		@(negedge clk);
		host_req.en = 1'b1;
		host_req.we = 1'b1;
		host_req.addr = cnn_pkg::fm_addr_t'(a);
		host_req.wdata = d;
		model_mem[a] = d;
	endtask

	task automatic host_read(input int a);
		@(negedge clk);
		host_req.en = 1'b1;
		host_req.we = 1'b0;
		host_req.addr = cnn_pkg::fm_addr_t'(a);
		host_req.wdata = '0;
	endtask

	task automatic host_idle();
		@(negedge clk);
		host_req = '0;
	endtask

	task automatic read_block(input int base, input int count);
		for (int i = 0; i < count; i++) begin
			host_read(base + i);
		end
	endtask

	// expected max pooling written straight into the mirror
	task automatic pool_model(input int src, input int dst, input int size,
		input int win, input int groups);
		int outs;
		int a;
		cnn_pkg::fm_word_t best;
		outs = size / win;
		for (int g = 0; g < groups; g++) begin
			for (int r = 0; r < outs; r++) begin
				for (int c = 0; c < outs; c++) begin
					for (int wy = 0; wy < win; wy++) begin
						for (int wx = 0; wx < win; wx++) begin
							a = src + (g * size + r * win + wy) * size + c * win + wx;
							for (int k = 0; k < cnn_pkg::PARA_Y; k++) begin
								if (wy == 0 && wx == 0) begin
									best[k] = model_mem[a][k];
								end else begin
									best[k] = larger_fp16(best[k], model_mem[a][k]);
								end
							end
						end
					end
					model_mem[dst + (g * outs + r) * outs + c] = best;
				end
			end
		end
	endtask

	task automatic run_pool_layer(input int num, input int size, input int win,
		input int groups, input int src, input int dst);
		int span;
		int n;
		span = groups * size * size;
		@(negedge clk);
		host_req = '0;
		layer_num = num[3:0];
		layer_type = cnn_pkg::LAYER_POOL;
		layer_cfg.fm_size = size[4:0];
		layer_cfg.fm_groups = groups[1:0];
		layer_cfg.pool_win = win[1:0];
		pool_model(src, dst, size, win, groups);
		host_idle(); // ready has dropped after this edge
		n = 0;
		while (!layer_ready && n < 20) begin
			host_read(src + int'($unsigned($random(seed)) % span)); // source half only
			host_idle();
			n++;
		end
		while (!layer_ready) @(negedge clk);
		read_block(dst, groups * (size / win) * (size / win));
		host_idle();
	endtask

	initial begin
		seed = 32'hf67e725f;
		errors = 0;
		rst = 1'b0;
		host_req = '0;
		layer_num = '0;
		layer_type = cnn_pkg::LAYER_LOAD;
		layer_cfg = '0;
		init_done = 1'b0;
		for (int a = 0; a < cnn_pkg::FM_RAM_DEPTH; a++) begin
			model_mem[a] = '0;
		end
		repeat (3) @(posedge clk);
		@(negedge clk);
		rst = 1'b1;
		@(negedge clk);
		assert (!layer_ready && !host_rvalid) else begin
			errors++;
			$display("layer_ready_o or host_rvalid_o is high right after reset");
		end

		@(negedge clk);
		layer_num = 4'd1; // new load layer
		for (int a = 0; a < 72; a++) begin
			w = rand_word();
			if (a == 0 || a == 1 || a == 6 || a == 7) begin
				w[0] = (a == 1) ? 16'h0000 : 16'h8000; // +0 among -0
				w[1][15] = 1'b1; // all negative window in lane 1
			end
			host_write(a, w);
		end
		for (int a = cnn_pkg::FM_RAM_HALF; a < cnn_pkg::FM_RAM_HALF + 32; a++) begin
			host_write(a, rand_word());
		end
		host_read(cnn_pkg::FM_RAM_HALF + 31); // right after its write
		read_block(0, 72);
		read_block(cnn_pkg::FM_RAM_HALF, 32);
		host_idle();
		@(negedge clk);
		init_done = 1'b1;
		while (!layer_ready) @(negedge clk);

		run_pool_layer(2, 6, 2, 2, 0, cnn_pkg::FM_RAM_HALF);
		run_pool_layer(3, 3, 3, 2, cnn_pkg::FM_RAM_HALF, 0); // halves swapped
		host_idle();
		host_idle();

		$display("Errors: %0d", errors);
		if (errors == 0) begin
			$display("Verification passed");
		end else begin
			$display("Verification failed");
		end
		$finish;
	end

endmodule

// File: vlog.f
src/cnn_pkg.sv
src/fm_ram.sv
src/fm_ram_arbiter.sv
src/max_pool_unit.sv
src/pool_engine.sv
src/layer_sequencer.sv
src/cnn_pool_top.sv
tb/tb_cnn_pool_top.sv

// File: run.sh
#!/usr/bin/env bash
# build the testbench with verilator and run it, pass only on the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --assert -Wno-fatal --top-module tb_cnn_pool_top \
	-f vlog.f -o sim_tb \
	&& ./obj_dir/sim_tb | tee /dev/stderr | grep -q "^Verification passed$" \
	&& echo "run.sh: simulation ok" \
	|| { echo "run.sh: build or simulation reported a problem"; exit 1; }
exit 0
